// File: rtl/dual_issue_defines.svh
`ifndef DI_FLUSH_GUARD
`define DI_FLUSH_GUARD

// data word and register index widths
`define DI_XLEN 32
`define DI_REG_W 5

// cycles with lanes_ready high that a long-latency destination stays owned
`define DI_LONG_LAT 2

// one bit per op_class_e value
// simple lane: alu, branch, mul, rdcnt, alu_branch, ibar
`define DI_SIMPLE_CLASS_MASK 16'h0393

// long latency producers: div, priv, mul, load_store
`define DI_LONG_CLASS_MASK 16'h003c

`endif

// File: rtl/dual_issue_pkg.sv
`include "dual_issue_defines.svh"

package dual_issue_pkg;

    // operation class as produced by decode
    typedef enum logic [3:0] {
        op_alu        = 4'd0,
        op_branch     = 4'd1,
        op_div        = 4'd2,
        op_priv       = 4'd3,
        op_mul        = 4'd4,
        op_load_store = 4'd5,
        op_priv_mem   = 4'd6,
        op_rdcnt      = 4'd7,
        op_alu_branch = 4'd8,
        op_ibar       = 4'd9,
        op_priv_mmu   = 4'd10,
        op_mmu        = 4'd11
    } op_class_e;

    // one decoded instruction
    typedef struct packed {
        logic [`DI_XLEN-1:0]  pc;
        logic [`DI_XLEN-1:0]  ir;
        op_class_e            op_class;
        logic                 reg_write;
        logic                 reads_rd;   // stores read their rd as data
        logic [`DI_REG_W-1:0] rd;
        logic [`DI_REG_W-1:0] rj;
        logic [`DI_REG_W-1:0] rk;
    } issue_slot_t;

    typedef enum logic [1:0] {
        pair_ready,
        split_pending,
        flushing
    } issue_state_e;

    localparam logic [15:0] simple_class_mask = `DI_SIMPLE_CLASS_MASK;
    localparam logic [15:0] long_class_mask   = `DI_LONG_CLASS_MASK;

    // class can execute on the simple lane
    function automatic logic is_simple_class(input op_class_e op);
        return simple_class_mask[op];
    endfunction

    // result arrives too late for back-to-back use
    function automatic logic is_long_latency(input op_class_e op);
        return long_class_mask[op];
    endfunction

endpackage

// File: rtl/issue_slot_if.sv
// one issued lane towards execute
interface issue_slot_if;

    logic                        valid;
    dual_issue_pkg::issue_slot_t slot;
    // shared stall from execute, same value on both lanes
    logic                        ready;

    // dispatcher side
    modport source (
        output valid,
        output slot,
        input  ready
    );

    // execute side
    modport sink (
        input  valid,
        input  slot,
        output ready
    );

endinterface

// File: rtl/pair_hazard_check.sv
`include "dual_issue_defines.svh"

module pair_hazard_check (
    input  dual_issue_pkg::issue_slot_t slot0,
    input  dual_issue_pkg::issue_slot_t slot1,
    input  logic [(1 << `DI_REG_W)-1:0] busy_mask,
    input  logic                        split_pending,
    output logic                        pair_ok,
    output logic                        older_blocked,
    output logic                        younger_blocked
);

    logic older_busy;
    logic younger_busy;
    logic older_writes;
    logic younger_dep;
    logic younger_simple;

    // any source of the slot still owned by a long producer
    function automatic logic slot_reads_busy(
        input dual_issue_pkg::issue_slot_t s,
        input logic [(1 << `DI_REG_W)-1:0] mask
    );
        return mask[s.rj] | mask[s.rk] | (s.reads_rd & mask[s.rd]);
    endfunction

    assign older_busy   = slot_reads_busy(slot0, busy_mask);
    assign younger_busy = slot_reads_busy(slot1, busy_mask);

    // r0 writes never create a dependence
    assign older_writes = slot0.reg_write & (slot0.rd != '0);

    // younger reads what the older produces
    assign younger_dep = older_writes
                       & ((slot1.rj == slot0.rd)
                       |  (slot1.rk == slot0.rd)
                       |  (slot1.reads_rd & (slot1.rd == slot0.rd)));

    assign younger_simple = dual_issue_pkg::is_simple_class(slot1.op_class);

    // older already left in split_pending, only the younger counts
    assign older_blocked   = ~split_pending & older_busy;
    assign younger_blocked = younger_busy;

    assign pair_ok = ~split_pending
                   & younger_simple
                   & ~younger_dep
                   & ~older_busy
                   & ~younger_busy;

endmodule

// File: rtl/pending_write_timer.sv
`include "dual_issue_defines.svh"

module pending_write_timer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush,
    input  logic                          advance,
    input  logic                          issue_full,
    input  logic                          issue_simple,
    input  dual_issue_pkg::issue_slot_t   full_slot,
    input  dual_issue_pkg::issue_slot_t   simple_slot,
    output logic [(1 << `DI_REG_W)-1:0]   busy_mask
);

    localparam int cnt_w = $clog2(`DI_LONG_LAT + 1);

    // entry 0 follows the full lane, entry 1 the simple lane
    dual_issue_pkg::issue_slot_t lane_slot [2];
    logic [1:0]                  lane_issue;
    logic [1:0]                  load;
    logic [`DI_REG_W-1:0]        owner_rd [2];
    logic [cnt_w-1:0]            count [2];

    assign lane_slot[0] = full_slot;
    assign lane_slot[1] = simple_slot;
    assign lane_issue   = {issue_simple, issue_full};

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            load[i] = lane_issue[i] & lane_slot[i].reg_write
                    & (lane_slot[i].rd != '0)
                    & dual_issue_pkg::is_long_latency(lane_slot[i].op_class);
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            for (int i = 0; i < 2; i++) begin
                count[i] <= '0;
            end
        end else if (advance) begin
            for (int i = 0; i < 2; i++) begin
                if (load[i]) begin
                    count[i] <= cnt_w'(`DI_LONG_LAT);
                end else if (count[i] != '0) begin
                    count[i] <= count[i] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (advance && load[i]) begin
                owner_rd[i] <= lane_slot[i].rd;
            end
        end
    end

    // live entries own their rd
    always_comb begin
        busy_mask = '0;
        for (int i = 0; i < 2; i++) begin
            if (count[i] != '0) begin
                busy_mask[owner_rd[i]] = 1'b1;
            end
        end
    end

endmodule

// File: rtl/issue_control_fsm.sv
module issue_control_fsm (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        flush,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  dual_issue_pkg::issue_slot_t slot0,
    input  dual_issue_pkg::issue_slot_t slot1,
    input  logic                        pair_ok,
    input  logic                        older_blocked,
    input  logic                        younger_blocked,
    output logic                        split_pending,
    output logic                        issue_full,
    output logic                        issue_simple,
    issue_slot_if.source                full_lane,
    issue_slot_if.source                simple_lane
);

    dual_issue_pkg::issue_state_e state;
    dual_issue_pkg::issue_state_e next_state;
    dual_issue_pkg::issue_slot_t  held_slot;
    dual_issue_pkg::issue_slot_t  full_next;
    dual_issue_pkg::issue_slot_t  full_slot_q;
    dual_issue_pkg::issue_slot_t  simple_slot_q;
    logic                         full_valid_q;
    logic                         simple_valid_q;
    logic                         advance;

    assign advance       = full_lane.ready & simple_lane.ready;
    assign split_pending = (state == dual_issue_pkg::split_pending);

    always_comb begin
        next_state   = state;
        issue_full   = 1'b0;
        issue_simple = 1'b0;
        in_ready     = 1'b0;
        full_next    = slot0;
        case (state)
            dual_issue_pkg::pair_ready: begin
                in_ready = ~in_valid | (~older_blocked & pair_ok);
                if (in_valid && !older_blocked) begin
                    // older always takes the full lane
                    issue_full = 1'b1;
                    if (pair_ok) begin
                        issue_simple = 1'b1;
                    end else begin
                        next_state = dual_issue_pkg::split_pending;
                    end
                end
            end
            dual_issue_pkg::split_pending: begin
                full_next = held_slot;
                if (!younger_blocked) begin
                    issue_full = 1'b1;
                    in_ready   = 1'b1;
                    next_state = dual_issue_pkg::pair_ready;
                end
            end
            default: begin
                next_state = dual_issue_pkg::pair_ready;
            end
        endcase
        // everything freezes under stall or flush
        if (!advance || flush) begin
            issue_full   = 1'b0;
            issue_simple = 1'b0;
            in_ready     = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            state          <= dual_issue_pkg::flushing;
            full_valid_q   <= 1'b0;
            simple_valid_q <= 1'b0;
        end else if (advance) begin
            state          <= next_state;
            full_valid_q   <= issue_full;
            simple_valid_q <= issue_simple;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_full) begin
            full_slot_q <= full_next;
        end
        if (issue_simple) begin
            simple_slot_q <= slot1;
        end
        // younger waits here while the older goes out alone
        if (issue_full && !issue_simple && state == dual_issue_pkg::pair_ready) begin
            held_slot <= slot1;
        end
    end

    assign full_lane.valid   = full_valid_q;
    assign full_lane.slot    = full_slot_q;
    assign simple_lane.valid = simple_valid_q;
    assign simple_lane.slot  = simple_slot_q;

endmodule

// File: rtl/dual_issue_top.sv
`include "dual_issue_defines.svh"

module dual_issue_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,

    // decoded pair, slot 0 older
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [`DI_XLEN-1:0]       pc0,
    input  logic [`DI_XLEN-1:0]       ir0,
    input  dual_issue_pkg::op_class_e class0,
    input  logic                      reg_write0,
    input  logic                      reads_rd0,
    input  logic [`DI_REG_W-1:0]      rd0,
    input  logic [`DI_REG_W-1:0]      rj0,
    input  logic [`DI_REG_W-1:0]      rk0,
    input  logic [`DI_XLEN-1:0]       pc1,
    input  logic [`DI_XLEN-1:0]       ir1,
    input  dual_issue_pkg::op_class_e class1,
    input  logic                      reg_write1,
    input  logic                      reads_rd1,
    input  logic [`DI_REG_W-1:0]      rd1,
    input  logic [`DI_REG_W-1:0]      rj1,
    input  logic [`DI_REG_W-1:0]      rk1,

    // full-function lane
    output logic                      full_valid,
    output logic [`DI_XLEN-1:0]       full_pc,
    output logic [`DI_XLEN-1:0]       full_ir,
    output dual_issue_pkg::op_class_e full_class,
    output logic [`DI_REG_W-1:0]      full_rd,
    output logic [`DI_REG_W-1:0]      full_rj,
    output logic [`DI_REG_W-1:0]      full_rk,
    output logic                      full_reg_write,

    // simple lane
    output logic                      simple_valid,
    output logic [`DI_XLEN-1:0]       simple_pc,
    output logic [`DI_XLEN-1:0]       simple_ir,
    output dual_issue_pkg::op_class_e simple_class,
    output logic [`DI_REG_W-1:0]      simple_rd,
    output logic [`DI_REG_W-1:0]      simple_rj,
    output logic [`DI_REG_W-1:0]      simple_rk,
    output logic                      simple_reg_write,

    input  logic                      lanes_ready
);

    dual_issue_pkg::issue_slot_t      slot0;
    dual_issue_pkg::issue_slot_t      slot1;
    dual_issue_pkg::issue_slot_t      timer_full_slot;
    logic [(1 << `DI_REG_W)-1:0]      busy_mask;
    logic                             pair_ok;
    logic                             older_blocked;
    logic                             younger_blocked;
    logic                             split_pending;
    logic                             issue_full;
    logic                             issue_simple;

    issue_slot_if full_lane_if ();
    issue_slot_if simple_lane_if ();

    assign slot0 = '{pc: pc0, ir: ir0, op_class: class0, reg_write: reg_write0,
                     reads_rd: reads_rd0, rd: rd0, rj: rj0, rk: rk0};
    assign slot1 = '{pc: pc1, ir: ir1, op_class: class1, reg_write: reg_write1,
                     reads_rd: reads_rd1, rd: rd1, rj: rj1, rk: rk1};

    // pair stays on the inputs until accepted, so slot 1 is the held younger
    assign timer_full_slot = split_pending ? slot1 : slot0;

    pair_hazard_check pair_hazard_check_i (
        .slot0           (slot0),
        .slot1           (slot1),
        .busy_mask       (busy_mask),
        .split_pending   (split_pending),
        .pair_ok         (pair_ok),
        .older_blocked   (older_blocked),
        .younger_blocked (younger_blocked)
    );

    pending_write_timer pending_write_timer_i (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .advance      (lanes_ready),
        .issue_full   (issue_full),
        .issue_simple (issue_simple),
        .full_slot    (timer_full_slot),
        .simple_slot  (slot1),
        .busy_mask    (busy_mask)
    );

    issue_control_fsm issue_control_fsm_i (
        .clk             (clk),
        .reset           (reset),
        .flush           (flush),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .slot0           (slot0),
        .slot1           (slot1),
        .pair_ok         (pair_ok),
        .older_blocked   (older_blocked),
        .younger_blocked (younger_blocked),
        .split_pending   (split_pending),
        .issue_full      (issue_full),
        .issue_simple    (issue_simple),
        .full_lane       (full_lane_if.source),
        .simple_lane     (simple_lane_if.source)
    );

    // one stall for both lanes
    assign full_lane_if.ready   = lanes_ready;
    assign simple_lane_if.ready = lanes_ready;

    assign full_valid     = full_lane_if.valid;
    assign full_pc        = full_lane_if.slot.pc;
    assign full_ir        = full_lane_if.slot.ir;
    assign full_class     = full_lane_if.slot.op_class;
    assign full_rd        = full_lane_if.slot.rd;
    assign full_rj        = full_lane_if.slot.rj;
    assign full_rk        = full_lane_if.slot.rk;
    assign full_reg_write = full_lane_if.slot.reg_write;

    assign simple_valid     = simple_lane_if.valid;
    assign simple_pc        = simple_lane_if.slot.pc;
    assign simple_ir        = simple_lane_if.slot.ir;
    assign simple_class     = simple_lane_if.slot.op_class;
    assign simple_rd        = simple_lane_if.slot.rd;
    assign simple_rj        = simple_lane_if.slot.rj;
    assign simple_rk        = simple_lane_if.slot.rk;
    assign simple_reg_write = simple_lane_if.slot.reg_write;

endmodule

// File: testbench/dual_issue_monitor.sv
`include "dual_issue_defines.svh"

module dual_issue_monitor #(
    parameter int rows = 12
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        flush,
    input  logic                        lanes_ready,
    input  logic                        in_ready,
    input  logic                        full_valid,
    input  logic [`DI_XLEN-1:0]         full_pc,
    input  logic [`DI_XLEN-1:0]         full_ir,
    input  logic [3:0]                  full_class,
    input  logic                        full_reg_write,
    input  logic [`DI_REG_W-1:0]        full_rd,
    input  logic [`DI_REG_W-1:0]        full_rj,
    input  logic [`DI_REG_W-1:0]        full_rk,
    input  logic                        simple_valid,
    input  logic [`DI_XLEN-1:0]         simple_pc,
    input  logic [`DI_XLEN-1:0]         simple_ir,
    input  logic [3:0]                  simple_class,
    input  logic                        simple_reg_write,
    input  logic [`DI_REG_W-1:0]        simple_rd,
    input  logic [`DI_REG_W-1:0]        simple_rj,
    input  logic [`DI_REG_W-1:0]        simple_rk,
    input  dual_issue_pkg::issue_slot_t exp_s0 [rows],
    input  dual_issue_pkg::issue_slot_t exp_s1 [rows],
    input  logic                        exp_paired [rows],
    output int                          rows_done,
    output logic                        failed
);

    int   ready_cycles = 0;
    int   prod_count [32];
    logic prod_valid [32];
    logic in_split = 1'b0;
    logic stalled = 1'b0;
    logic [2*`DI_XLEN+1:0] held_lanes;

    initial begin
        failed    = 1'b0;
        rows_done = 0;
        for (int r = 0; r < 32; r++) begin
            prod_valid[r] = 1'b0;
            prod_count[r] = 0;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, expected);
            failed = 1'b1;
        end
    endtask

    // every lane field against its table row
    task automatic compare_item(input string lane, input dual_issue_pkg::issue_slot_t want,
                                input logic [31:0] pc, input logic [31:0] ir,
                                input logic [3:0] cls, input logic rw, input logic [4:0] rd,
                                input logic [4:0] rj, input logic [4:0] rk);
        check_value({lane, "_pc"}, pc, want.pc);
        check_value({lane, "_ir"}, ir, want.ir);
        check_value({lane, "_class"}, 32'(cls), 32'(want.op_class));
        check_value({lane, "_reg_write"}, 32'(rw), 32'(want.reg_write));
        check_value({lane, "_rd"}, 32'(rd), 32'(want.rd));
        check_value({lane, "_rj"}, 32'(rj), 32'(want.rj));
        check_value({lane, "_rk"}, 32'(rk), 32'(want.rk));
    endtask

    // div, priv, mul and loads deliver late
    function automatic logic slow_class(input logic [3:0] cls);
        return cls == 4'd2 || cls == 4'd3 || cls == 4'd4 || cls == 4'd5;
    endfunction

    task automatic check_source(input logic [4:0] r);
        if (r != 5'd0 && prod_valid[r]) begin
            check_value($sformatf("ready cycles after producer of r%0d", r),
                        32'(ready_cycles - prod_count[r] >= `DI_LONG_LAT), 32'd1);
        end
    endtask

    task automatic track_item(input logic [3:0] cls, input logic rw, input logic [4:0] rd,
                              input logic [4:0] rj, input logic [4:0] rk);
        check_source(rj);
        check_source(rk);
        // stores read rd as data
        if (cls == 4'd5 && !rw) begin
            check_source(rd);
        end
        if (rw && rd != 5'd0 && slow_class(cls)) begin
            prod_valid[rd] = 1'b1;
            prod_count[rd] = ready_cycles;
        end
    endtask

    always @(posedge clk) begin
        if (stalled) begin
            check_value("held lane state", 32'(held_lanes != {full_valid, simple_valid,
                        full_pc, simple_pc}), 32'd0);
        end
        stalled    = !lanes_ready && !flush && !reset;
        held_lanes = {full_valid, simple_valid, full_pc, simple_pc};
        if (!lanes_ready) begin
            check_value("in_ready", 32'(in_ready), 32'd0);
        end
        if (lanes_ready && !reset) begin
            ready_cycles = ready_cycles + 1;
            if (full_valid) begin
                if (rows_done >= rows) begin
                    check_value("full_valid after last row", 32'd1, 32'd0);
                end else if (!in_split) begin
                    compare_item("full", exp_s0[rows_done], full_pc, full_ir, full_class,
                                 full_reg_write, full_rd, full_rj, full_rk);
                    check_value("simple_valid", 32'(simple_valid), 32'(exp_paired[rows_done]));
                    if (exp_paired[rows_done]) begin
                        compare_item("simple", exp_s1[rows_done], simple_pc, simple_ir,
                                     simple_class, simple_reg_write, simple_rd, simple_rj,
                                     simple_rk);
                        rows_done = rows_done + 1;
                    end else begin
                        in_split = 1'b1;
                    end
                end else begin
                    // held younger comes back on the full lane only
                    compare_item("full", exp_s1[rows_done], full_pc, full_ir, full_class,
                                 full_reg_write, full_rd, full_rj, full_rk);
                    check_value("simple_valid", 32'(simple_valid), 32'd0);
                    in_split  = 1'b0;
                    rows_done = rows_done + 1;
                end
                track_item(full_class, full_reg_write, full_rd, full_rj, full_rk);
            end else begin
                check_value("simple_valid without full lane", 32'(simple_valid), 32'd0);
            end
            if (simple_valid) begin
                track_item(simple_class, simple_reg_write, simple_rd, simple_rj, simple_rk);
            end
        end
        if (flush) begin
            // flushed row ends with its older instruction
            if (in_split) begin
                rows_done = rows_done + 1;
            end
            in_split = 1'b0;
            for (int r = 0; r < 32; r++) begin
                prod_valid[r] = 1'b0;
            end
        end
    end

endmodule

// File: testbench/dual_issue_tb.sv
`include "dual_issue_defines.svh"

module dual_issue_tb;

    localparam int rows = 12;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic flush = 1'b0;
    logic in_valid = 1'b0;
    logic lanes_ready = 1'b1;
    logic force_ready = 1'b1;
    int   seed = 32'h3c69;
    dual_issue_pkg::issue_slot_t s0 = '0;
    dual_issue_pkg::issue_slot_t s1 = '0;

    dual_issue_pkg::issue_slot_t row_s0 [rows];
    dual_issue_pkg::issue_slot_t row_s1 [rows];
    logic        exp_paired [rows];
    logic        exp_flushed [rows];

    logic        in_ready, full_valid, simple_valid, full_reg_write, simple_reg_write;
    logic [31:0] full_pc, full_ir, simple_pc, simple_ir;
    logic [4:0]  full_rd, full_rj, full_rk, simple_rd, simple_rj, simple_rk;
    dual_issue_pkg::op_class_e full_class, simple_class;
    int          rows_done;
    logic        failed;

    always #5 clk = ~clk;

    // mostly ready, with random stalls
    always @(posedge clk) begin
        lanes_ready <= force_ready || (($random(seed) & 32'h3) != 0);
    end

    dual_issue_top dual_issue_top_i (
        .clk(clk), .reset(reset), .flush(flush), .in_valid(in_valid), .in_ready(in_ready),
        .pc0(s0.pc), .ir0(s0.ir), .class0(s0.op_class), .reg_write0(s0.reg_write),
        .reads_rd0(s0.reads_rd), .rd0(s0.rd), .rj0(s0.rj), .rk0(s0.rk),
        .pc1(s1.pc), .ir1(s1.ir), .class1(s1.op_class), .reg_write1(s1.reg_write),
        .reads_rd1(s1.reads_rd), .rd1(s1.rd), .rj1(s1.rj), .rk1(s1.rk),
        .full_valid(full_valid), .full_pc(full_pc), .full_ir(full_ir),
        .full_class(full_class), .full_rd(full_rd), .full_rj(full_rj), .full_rk(full_rk),
        .full_reg_write(full_reg_write), .simple_valid(simple_valid),
        .simple_pc(simple_pc), .simple_ir(simple_ir), .simple_class(simple_class),
        .simple_rd(simple_rd), .simple_rj(simple_rj), .simple_rk(simple_rk),
        .simple_reg_write(simple_reg_write), .lanes_ready(lanes_ready)
    );

    dual_issue_monitor #(.rows(rows)) dual_issue_monitor_i (
        .clk(clk), .reset(reset), .flush(flush), .lanes_ready(lanes_ready),
        .in_ready(in_ready), .full_valid(full_valid), .full_pc(full_pc),
        .full_ir(full_ir), .full_class(full_class), .full_reg_write(full_reg_write),
        .full_rd(full_rd), .full_rj(full_rj), .full_rk(full_rk),
        .simple_valid(simple_valid), .simple_pc(simple_pc), .simple_ir(simple_ir),
        .simple_class(simple_class), .simple_reg_write(simple_reg_write),
        .simple_rd(simple_rd), .simple_rj(simple_rj), .simple_rk(simple_rk),
        .exp_s0(row_s0), .exp_s1(row_s1), .exp_paired(exp_paired),
        .rows_done(rows_done), .failed(failed)
    );

    function automatic dual_issue_pkg::issue_slot_t make_slot(
        input logic [31:0] pc, input dual_issue_pkg::op_class_e cls, input logic rw,
        input logic rrd, input logic [4:0] rd, input logic [4:0] rj, input logic [4:0] rk
    );
        return '{pc: pc, ir: ~pc, op_class: cls, reg_write: rw, reads_rd: rrd,
                 rd: rd, rj: rj, rk: rk};
    endfunction

    task automatic add_row(input int i, input dual_issue_pkg::op_class_e c0,
                           input logic [14:0] regs0, input dual_issue_pkg::op_class_e c1,
                           input logic [14:0] regs1, input logic paired, input logic flushed);
        logic [31:0] pc;
        pc             = 32'h1000 + 32'(8 * i);
        // store class without a write reads its rd
        row_s0[i]      = make_slot(pc, c0, regs0[14:10] != 0 && c0 != dual_issue_pkg::op_branch
                                   && !(c0 == dual_issue_pkg::op_load_store && i == 8),
                                   c0 == dual_issue_pkg::op_load_store && i == 8,
                                   regs0[14:10], regs0[9:5], regs0[4:0]);
        row_s1[i]      = make_slot(pc + 32'd4, c1, regs1[14:10] != 0, 1'b0,
                                   regs1[14:10], regs1[9:5], regs1[4:0]);
        exp_paired[i]  = paired;
        exp_flushed[i] = flushed;
    endtask

    initial begin
        int limit;
        limit = rows * (`DI_LONG_LAT + 4) * 20 * 10;
        #(limit);
        $display("run timed out at %0t with %0d rows done", $time, rows_done);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    always @(posedge failed) begin
        $display("SOME TESTS FAILED");
        $fatal(1, "first check failed");
    end

    initial begin
        int waited;
        // rows hold {rd, rj, rk}
        add_row(0, dual_issue_pkg::op_alu, {5'd1, 5'd2, 5'd3},
                dual_issue_pkg::op_alu, {5'd4, 5'd5, 5'd6}, 1'b1, 1'b0);
        add_row(1, dual_issue_pkg::op_alu, {5'd7, 5'd1, 5'd0},
                dual_issue_pkg::op_alu, {5'd8, 5'd7, 5'd0}, 1'b0, 1'b0);
        add_row(2, dual_issue_pkg::op_alu, {5'd9, 5'd1, 5'd2},
                dual_issue_pkg::op_div, {5'd10, 5'd3, 5'd4}, 1'b0, 1'b0);
        add_row(3, dual_issue_pkg::op_alu, {5'd11, 5'd12, 5'd13},
                dual_issue_pkg::op_branch, {5'd0, 5'd14, 5'd15}, 1'b1, 1'b0);
        add_row(4, dual_issue_pkg::op_load_store, {5'd5, 5'd2, 5'd0},
                dual_issue_pkg::op_alu, {5'd3, 5'd6, 5'd7}, 1'b1, 1'b0);
        add_row(5, dual_issue_pkg::op_alu, {5'd6, 5'd5, 5'd0},
                dual_issue_pkg::op_alu, {5'd12, 5'd13, 5'd14}, 1'b1, 1'b0);
        add_row(6, dual_issue_pkg::op_load_store, {5'd20, 5'd1, 5'd0},
                dual_issue_pkg::op_alu, {5'd21, 5'd20, 5'd0}, 1'b0, 1'b0);
        add_row(7, dual_issue_pkg::op_load_store, {5'd22, 5'd1, 5'd0},
                dual_issue_pkg::op_alu, {5'd2, 5'd3, 5'd4}, 1'b1, 1'b0);
        add_row(8, dual_issue_pkg::op_load_store, {5'd22, 5'd1, 5'd0},
                dual_issue_pkg::op_alu, {5'd23, 5'd9, 5'd11}, 1'b1, 1'b0);
        add_row(9, dual_issue_pkg::op_mul, {5'd24, 5'd1, 5'd2},
                dual_issue_pkg::op_mul, {5'd25, 5'd3, 5'd4}, 1'b1, 1'b0);
        // older issues, younger waits on the mul result when the flush hits
        add_row(10, dual_issue_pkg::op_alu, {5'd26, 5'd1, 5'd0},
                dual_issue_pkg::op_alu, {5'd27, 5'd24, 5'd0}, 1'b0, 1'b1);
        add_row(11, dual_issue_pkg::op_alu, {5'd26, 5'd24, 5'd0},
                dual_issue_pkg::op_rdcnt, {5'd27, 5'd0, 5'd0}, 1'b1, 1'b0);

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        dual_issue_monitor_i.check_value("full_valid", 32'(full_valid), 32'd0);
        dual_issue_monitor_i.check_value("simple_valid", 32'(simple_valid), 32'd0);
        waited = 0;
        @(posedge clk);
        while (!in_ready && waited < 2) begin
            waited++;
            @(posedge clk);
        end
        dual_issue_monitor_i.check_value("in_ready", 32'(in_ready), 32'd1);
        force_ready <= 1'b0;

        for (int i = 0; i < rows; i++) begin
            // keep execute ready around the flushed row so its neighbours drain
            force_ready <= exp_flushed[i] || (i + 1 < rows && exp_flushed[i + 1]);
            s0          <= row_s0[i];
            s1          <= row_s1[i];
            in_valid    <= 1'b1;
            @(posedge clk);
            if (exp_flushed[i]) begin
                dual_issue_monitor_i.check_value("in_ready", 32'(in_ready), 32'd0);
                flush    <= 1'b1;
                in_valid <= 1'b0;
                @(posedge clk);
                flush <= 1'b0;
            end else begin
                while (!in_ready) begin
                    @(posedge clk);
                end
            end
        end
        in_valid    <= 1'b0;
        force_ready <= 1'b0;

        while (rows_done < rows) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (failed) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "checks failed");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// File: filelist.f
+incdir+rtl
rtl/dual_issue_pkg.sv
rtl/issue_slot_if.sv
rtl/pair_hazard_check.sv
rtl/pending_write_timer.sv
rtl/issue_control_fsm.sv
rtl/dual_issue_top.sv
testbench/dual_issue_monitor.sv
testbench/dual_issue_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the dual-issue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module dual_issue_tb \
    --Mdir obj_dir -o dual_issue_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

output=$(./obj_dir/dual_issue_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
